/* hw/dcache_pkg.sv */
`default_nettype none

package dcache_pkg;

    ////////////////////
    // Widths
    ////////////////////

    parameter int addr_w = 32;              // Processor address width

    typedef logic [63:0] line_data_t;       // One cached line, a single 64-bit word
    typedef logic [3:0]  mem_tag_t;         // Memory transaction tag, 0 means none

    ////////////////////
    // Bus commands
    ////////////////////

    // Same encoding the memory bus has always used
    typedef enum logic [1:0] {
        bus_none  = 2'h0,
        bus_load  = 2'h1,
        bus_store = 2'h2
    } bus_cmd_t;

    ////////////////////
    // Execute stage side
    ////////////////////

    // Held as a level until rsp.valid is seen
    typedef struct packed {
        bus_cmd_t           command;        // Load, store or nothing
        logic [addr_w-1:0]  addr;           // Word address, low bits ignored
        line_data_t         data;           // Store data
    } dcache_req_t;

    typedef struct packed {
        line_data_t data;                   // Load data, or the stored word
        logic       valid;                  // Request finished this cycle
    } dcache_rsp_t;

    ////////////////////
    // Memory side
    ////////////////////

    typedef struct packed {
        bus_cmd_t           command;        // Held until response is nonzero
        logic [addr_w-1:0]  addr;           // Line aligned
        line_data_t         data;           // Write-through data
    } mem_req_t;

    typedef struct packed {
        mem_tag_t   response;               // Nonzero in the acceptance cycle
        line_data_t data;                   // Load data, valid with tag
        mem_tag_t   tag;                    // Nonzero when data for that transaction returns
    } mem_rsp_t;

    // Controller states
    typedef enum logic [2:0] {
        idle,
        load_req,
        load_wait,
        store_req,
        done
    } ctrl_state_t;

endpackage

`default_nettype wire

/* hw/dcache_array.sv */
`default_nettype none
`timescale 1ns/1ps

module dcache_array #(
    parameter int cache_lines      = 32,   // Power of two
    parameter int cached_addr_bits = 16    // Width of the cached address window
) (
    input  wire logic                          clock,
    input  wire logic                          reset,

    // Lookup address from the request
    input  wire logic [dcache_pkg::addr_w-1:0] addr,

    // Line write from the controller
    input  wire logic                          fill,
    input  wire dcache_pkg::line_data_t        fill_data,

    // Lookup result
    output logic                               hit,
    output dcache_pkg::line_data_t             rd_data
);

    ////////////////////
    // Address split
    ////////////////////

    localparam int index_w = $clog2(cache_lines);
    localparam int tag_w   = cached_addr_bits - 3 - index_w;   // 3 offset bits below the index

    logic [index_w-1:0] addr_index;
    logic [tag_w-1:0]   addr_tag;

    // Only the cached window matters, upper bits alias
    assign {addr_tag, addr_index} = addr[cached_addr_bits-1:3];

    ////////////////////
    // Line storage
    ////////////////////

    typedef struct packed {
        logic                   valid;      // Line holds memory data
        logic [tag_w-1:0]       tag;        // Upper part of the cached window
        dcache_pkg::line_data_t data;       // The 8-byte line
    } entry_t;

    entry_t entries [cache_lines];

    entry_t cur_entry;                      // Entry picked by the index

    assign cur_entry = entries[addr_index];

    // Tag compare
    assign hit     = cur_entry.valid && (cur_entry.tag == addr_tag);
    assign rd_data = cur_entry.data;        // Read is combinational, used on hit and in done

    // Write port
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < cache_lines; i++) begin
                entries[i].valid <= 1'b0;   // Tags and data keep whatever they had
            end
        end else if (fill) begin
            // Whole line replaced, both for miss fill and store allocate
            entries[addr_index].valid <= 1'b1;
            entries[addr_index].tag   <= addr_tag;
            entries[addr_index].data  <= fill_data;
        end
    end

endmodule

`default_nettype wire

/* hw/dcache_mem_tracker.sv */
`default_nettype none
`timescale 1ns/1ps

module dcache_mem_tracker (
    input  wire logic                 clock,
    input  wire logic                 reset,

    // Load accepted this cycle
    input  wire logic                 capture,

    // Memory response bus
    input  wire dcache_pkg::mem_rsp_t mem_rsp,

    // Data for our transaction is on the bus
    output logic                      data_here
);

    ////////////////////
    // Held tag
    ////////////////////

    dcache_pkg::mem_tag_t held_tag;         // Tag memory gave the outstanding load
    logic                 tag_live;         // A nonzero tag is held

    assign tag_live = (held_tag != '0);

    // Tag 0 never matches, the bus idles at 0
    assign data_here = tag_live && (mem_rsp.tag == held_tag);

    always_ff @(posedge clock) begin
        if (reset) begin
            held_tag <= '0;
        end else if (capture) begin
            held_tag <= mem_rsp.response;   // Nonzero by definition of acceptance
        end else if (data_here) begin
            // Drop the tag once the data is taken
            // so a later reuse of the same number by memory cannot match
            held_tag <= '0;
        end
    end

endmodule

`default_nettype wire

/* hw/dcache_ctrl.sv */
`default_nettype none
`timescale 1ns/1ps

module dcache_ctrl (
    input  wire logic                   clock,
    input  wire logic                   reset,

    // Execute stage
    input  wire dcache_pkg::dcache_req_t req,

    // From the array
    input  wire logic                   hit,
    input  wire dcache_pkg::line_data_t rd_data,

    // From the tracker
    input  wire logic                   data_here,

    // Memory response bus
    input  wire dcache_pkg::mem_rsp_t   mem_rsp,

    // Memory command bus
    output dcache_pkg::mem_req_t        mem_req,

    // To the tracker
    output logic                        capture,

    // To the array
    output logic                        fill,
    output dcache_pkg::line_data_t      fill_data,

    // Back to execute
    output dcache_pkg::dcache_rsp_t     rsp,
    output logic                        stall
);

    ////////////////////
    // Request decode
    ////////////////////

    dcache_pkg::ctrl_state_t state, state_next;

    logic is_load;                          // Execute wants a load
    logic is_store;                         // Execute wants a store
    logic accepted;                         // Memory took the held command

    assign is_load  = (req.command == dcache_pkg::bus_load);
    assign is_store = (req.command == dcache_pkg::bus_store);
    assign accepted = (mem_rsp.response != '0);

    ////////////////////
    // Bus side
    ////////////////////

    always_comb begin
        mem_req.addr    = {req.addr[dcache_pkg::addr_w-1:3], 3'b000};  // Line aligned
        mem_req.data    = req.data;         // Only meaningful with bus_store
        mem_req.command = dcache_pkg::bus_none;
        if (state == dcache_pkg::load_req) begin
            mem_req.command = dcache_pkg::bus_load;
        end else if (state == dcache_pkg::store_req) begin
            mem_req.command = dcache_pkg::bus_store;
        end
    end

    // Tag is only worth keeping for loads, stores get no data back
    assign capture = (state == dcache_pkg::load_req) && accepted;

    // Line write on fill return or on store acceptance
    assign fill = ((state == dcache_pkg::load_wait) && data_here) ||
                  ((state == dcache_pkg::store_req) && accepted);

    // Fill source, store data or returning memory data
    assign fill_data = (state == dcache_pkg::store_req) ? req.data : mem_rsp.data;

    ////////////////////
    // Response side
    ////////////////////

    always_comb begin
        rsp.data  = rd_data;                // Array read at the request address
        rsp.valid = 1'b0;
        if (state == dcache_pkg::done) begin
            rsp.valid = 1'b1;               // Filled or stored line is in the array now
        end else if (state == dcache_pkg::idle) begin
            rsp.valid = is_load && hit;     // Same-cycle hit
        end
    end

    // Request present and not answered
    assign stall = (is_load || is_store) && !rsp.valid;

    ////////////////////
    // FSM
    ////////////////////

    always_comb begin
        state_next = state;
        case (state)
            dcache_pkg::idle: begin
                if (is_store) begin
                    state_next = dcache_pkg::store_req;     // Every store goes to memory
                end else if (is_load && !hit) begin
                    state_next = dcache_pkg::load_req;
                end
            end
            dcache_pkg::load_req: begin
                if (accepted) state_next = dcache_pkg::load_wait;  // Refused, keep holding
            end
            dcache_pkg::load_wait: begin
                if (data_here) state_next = dcache_pkg::done;
            end
            dcache_pkg::store_req: begin
                if (accepted) state_next = dcache_pkg::done;
            end
            dcache_pkg::done: begin
                state_next = dcache_pkg::idle;              // Next request arrives now
            end
            default: begin
                state_next = dcache_pkg::idle;
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= dcache_pkg::idle;
        end else begin
            state <= state_next;
        end
    end

endmodule

`default_nettype wire

/* hw/dcache_top.sv */
`default_nettype none
`timescale 1ns/1ps

module dcache_top #(
    parameter int cache_lines      = 32,   // Number of lines, power of two
    parameter int cached_addr_bits = 16    // Cached physical window
) (
    input  wire logic                    clock,
    input  wire logic                    reset,

    // Execute stage
    input  wire dcache_pkg::dcache_req_t req,
    output dcache_pkg::dcache_rsp_t      rsp,
    output logic                         stall,

    // Memory bus
    input  wire dcache_pkg::mem_rsp_t    mem_rsp,
    output dcache_pkg::mem_req_t         mem_req
);

    ////////////////////
    // Internal wires
    ////////////////////

    logic                   hit;            // Array lookup result
    dcache_pkg::line_data_t rd_data;        // Indexed line
    logic                   fill;           // Line write strobe
    dcache_pkg::line_data_t fill_data;      // Memory data or store data
    logic                   capture;        // Load accepted by memory
    logic                   data_here;      // Our load data is on the bus

    // Sequencing
    dcache_ctrl ctrl_i (
        .clock     (clock),
        .reset     (reset),
        .req       (req),
        .hit       (hit),
        .rd_data   (rd_data),
        .data_here (data_here),
        .mem_rsp   (mem_rsp),
        .mem_req   (mem_req),
        .capture   (capture),
        .fill      (fill),
        .fill_data (fill_data),
        .rsp       (rsp),
        .stall     (stall)
    );

    // Storage, looked up with the live request address
    dcache_array #(
        .cache_lines      (cache_lines),
        .cached_addr_bits (cached_addr_bits)
    ) array_i (
        .clock     (clock),
        .reset     (reset),
        .addr      (req.addr),
        .fill      (fill),
        .fill_data (fill_data),
        .hit       (hit),
        .rd_data   (rd_data)
    );

    // Outstanding load tag
    dcache_mem_tracker tracker_i (
        .clock     (clock),
        .reset     (reset),
        .capture   (capture),
        .mem_rsp   (mem_rsp),
        .data_here (data_here)
    );

endmodule

`default_nettype wire

/* tb/mem_model.sv */
`default_nettype none
`timescale 1ns/1ps

module mem_model #(
    parameter int window_bits = 16,            // Physical memory behind the cache
    parameter int latency     = 4              // Acceptance to load data, in cycles
) (
    input  wire logic                 clock,
    input  wire logic                 reset,
    input  wire dcache_pkg::mem_req_t mem_req,
    output dcache_pkg::mem_rsp_t      mem_rsp,
    input  wire logic [31:0]          peek_addr,   // Word the testbench looks at
    output logic [63:0]               peek_data,
    output int                        load_count   // Accepted loads
);

    localparam int words = 2 ** (window_bits - 3);

    logic [63:0]            mem [words];
    dcache_pkg::mem_tag_t   next_tag;          // Rotates 1 to 15
    dcache_pkg::mem_tag_t   pend_tag;          // Tag of the load in flight
    logic [window_bits-4:0] pend_idx;
    int                     pend_cnt;          // Cycles left until data returns
    logic [window_bits-4:0] req_idx;

    assign req_idx   = mem_req.addr[window_bits-1:3];   // Upper address bits alias
    assign peek_data = mem[peek_addr[window_bits-1:3]];

    // Known contents, every word differs
    function automatic logic [63:0] initial_word(int unsigned w);
        return {16'hc0de, w[15:0], w * 32'h9e3779b1};
    endfunction

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int w = 0; w < words; w++) begin
                mem[w] <= initial_word(w);
            end
            mem_rsp    <= '0;
            next_tag   <= 4'd1;
            pend_tag   <= '0;
            pend_idx   <= '0;
            pend_cnt   <= 0;
            load_count <= 0;
        end else begin
            mem_rsp.tag <= '0;                 // Data tag is a one-cycle pulse
            if (pend_cnt == 1) begin
                mem_rsp.tag  <= pend_tag;
                mem_rsp.data <= mem[pend_idx];
            end
            if (pend_cnt > 0) begin
                pend_cnt <= pend_cnt - 1;
            end
            if (mem_rsp.response != '0) begin
                // Acceptance cycle, command applied now
                mem_rsp.response <= '0;
                if (mem_req.command == dcache_pkg::bus_store) begin
                    mem[req_idx] <= mem_req.data;
                end else if (mem_req.command == dcache_pkg::bus_load) begin
                    pend_tag   <= mem_rsp.response;
                    pend_idx   <= req_idx;
                    pend_cnt   <= latency;
                    load_count <= load_count + 1;
                end
            end else if (mem_req.command != dcache_pkg::bus_none) begin
                if ($urandom % 3 != 0) begin   // Refused one time in three
                    mem_rsp.response <= next_tag;
                    next_tag <= (next_tag == 4'd15) ? 4'd1 : next_tag + 4'd1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* tb/dcache_tb.sv */
`default_nettype none
`timescale 1ns/1ps

module dcache_tb;

    localparam int cache_lines      = 32;
    localparam int cached_addr_bits = 16;
    localparam int index_w          = $clog2(cache_lines);
    localparam int tag_w            = cached_addr_bits - 3 - index_w;
    localparam int words            = 2 ** (cached_addr_bits - 3);
    localparam int op_count         = 17;
    localparam int wait_limit       = 200;     // Cycles allowed per operation

    typedef struct packed {
        dcache_pkg::bus_cmd_t command;
        logic [31:0]          addr;
        logic [63:0]          data;            // Store data
    } op_t;

    logic                    clock;
    logic                    reset;
    dcache_pkg::dcache_req_t req;
    dcache_pkg::dcache_rsp_t rsp;
    logic                    stall;
    dcache_pkg::mem_req_t    mem_req;
    dcache_pkg::mem_rsp_t    mem_rsp;
    logic [63:0]             peek_data;        // Memory word at the request address
    int                      load_count;

    op_t         ops [op_count];
    logic [63:0] shadow_mem [words];
    logic        shadow_valid [cache_lines];
    logic [tag_w-1:0] shadow_tag [cache_lines];
    int          checks;
    int          errors;

    initial clock = 1'b0;
    always #20 clock = ~clock;

    dcache_top #(
        .cache_lines      (cache_lines),
        .cached_addr_bits (cached_addr_bits)
    ) dcache_top_i (
        .clock   (clock),
        .reset   (reset),
        .req     (req),
        .rsp     (rsp),
        .stall   (stall),
        .mem_rsp (mem_rsp),
        .mem_req (mem_req)
    );

    mem_model #(.window_bits(cached_addr_bits)) mem_model_i (
        .clock      (clock),
        .reset      (reset),
        .mem_req    (mem_req),
        .mem_rsp    (mem_rsp),
        .peek_addr  (req.addr),
        .peek_data  (peek_data),
        .load_count (load_count)
    );

    function automatic logic [63:0] pattern_word(int unsigned w);
        return {16'hc0de, w[15:0], w * 32'h9e3779b1};
    endfunction

    task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error: %s is %h, expected %h at %0t", name, got, exp, $time);
        end
    endtask

    ////////////////////
    // Operation table
    ////////////////////

    initial begin
        ops[0]  = '{dcache_pkg::bus_load,  32'h0000_0040, 64'h0};  // Cold miss
        ops[1]  = '{dcache_pkg::bus_load,  32'h0000_0040, 64'h0};  // Same line hits
        ops[2]  = '{dcache_pkg::bus_store, 32'h0000_0048, 64'h1111_2222_3333_4444};
        ops[3]  = '{dcache_pkg::bus_load,  32'h0000_0048, 64'h0};  // Allocated by store
        ops[4]  = '{dcache_pkg::bus_load,  32'h0000_0140, 64'h0};  // Index 8, tag 1
        ops[5]  = '{dcache_pkg::bus_load,  32'h0000_0040, 64'h0};  // Evicted
        ops[6]  = '{dcache_pkg::bus_load,  32'h0000_0140, 64'h0};
        ops[7]  = '{dcache_pkg::bus_load,  32'h0001_0140, 64'h0};  // Alias above window
        ops[8]  = '{dcache_pkg::bus_store, 32'h0001_0048, 64'hdead_beef_0bad_f00d};
        ops[9]  = '{dcache_pkg::bus_load,  32'h0000_0048, 64'h0};
        ops[10] = '{dcache_pkg::bus_store, 32'h0000_2000, 64'h0123_4567_89ab_cdef};
        ops[11] = '{dcache_pkg::bus_store, 32'h0000_fff8, 64'hfeed_face_cafe_babe};
        ops[12] = '{dcache_pkg::bus_load,  32'h0000_3000, 64'h0};  // Index 0, new tag
        ops[13] = '{dcache_pkg::bus_load,  32'h0000_2000, 64'h0};
        ops[14] = '{dcache_pkg::bus_load,  32'h0000_fff8, 64'h0};  // Readback of stores
        ops[15] = '{dcache_pkg::bus_load,  32'h0000_0048, 64'h0};
        ops[16] = '{dcache_pkg::bus_load,  32'h0001_2000, 64'h0};
    end

    ////////////////////
    // Main sequence
    ////////////////////

    initial begin
        op_t              op;
        int               cycles;
        int               loads_before;
        int               idx;
        logic [tag_w-1:0] tag;
        logic             predict_miss;
        void'($urandom(87));
        checks = 0;
        errors = 0;
        reset  = 1'b1;
        req    = '0;
        for (int w = 0; w < words; w++) begin
            shadow_mem[w] = pattern_word(w);
        end
        for (int i = 0; i < cache_lines; i++) begin
            shadow_valid[i] = 1'b0;
        end
        repeat (2) @(posedge clock);
        reset <= 1'b0;
        @(negedge clock);
        compare("rsp.valid", rsp.valid, 0);                // Quiet after reset
        compare("stall", stall, 0);
        compare("mem_req.command", mem_req.command, dcache_pkg::bus_none);
        for (int i = 0; i < op_count; i++) begin
            op  = ops[i];
            idx = int'(op.addr[index_w+2:3]);
            tag = op.addr[cached_addr_bits-1:index_w+3];   // Window bits only
            predict_miss = (op.command == dcache_pkg::bus_load) &&
                           !(shadow_valid[idx] && shadow_tag[idx] == tag);
            loads_before = load_count;
            @(posedge clock);
            req <= '{command: op.command, addr: op.addr, data: op.data};
            @(negedge clock);
            cycles = 0;
            while (!rsp.valid && cycles < wait_limit) begin
                compare("stall", stall, 1);                // Held until valid
                @(negedge clock);
                cycles++;
            end
            if (!rsp.valid) begin
                $display("Timeout: operation %0d at address %h got no response", i, op.addr);
                errors++;
                break;
            end
            compare("stall", stall, 0);
            compare("bus loads", load_count - loads_before, predict_miss);
            if (op.command == dcache_pkg::bus_load) begin
                compare("rsp.data", rsp.data, shadow_mem[op.addr[cached_addr_bits-1:3]]);
                if (!predict_miss) begin
                    compare("hit delay", cycles, 0);        // Same-cycle answer
                end
            end else begin
                shadow_mem[op.addr[cached_addr_bits-1:3]] = op.data;
                compare("memory word", peek_data, op.data); // Written through
            end
            shadow_valid[idx] = 1'b1;
            shadow_tag[idx]   = tag;
        end
        @(posedge clock);
        req <= '0;
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* build.f */
hw/dcache_pkg.sv
hw/dcache_array.sv
hw/dcache_mem_tracker.sv
hw/dcache_ctrl.sv
hw/dcache_top.sv
tb/mem_model.sv
tb/dcache_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the cache testbench, the log decides the result
verilator --binary --timing -Wno-fatal --top-module dcache_tb -f build.f -o dcache_sim \
    > sim.log 2>&1 &&
    ./obj_dir/dcache_sim >> sim.log 2>&1 ||
    { cat sim.log; echo "Build or simulation did not run to the end"; exit 1; }
cat sim.log
grep -q "Done: errors found" sim.log && { echo "FAIL"; exit 1; } || echo "PASS"
exit 0
